//--- src/sram_settings.svh
`ifndef SRAM_SETTINGS_SVH
`define SRAM_SETTINGS_SVH

////////////////////////////////////////
// External SRAM geometry
////////////////////////////////////////

// Word address and data width of the chip
`define SRAM_ADDR_W 18
`define SRAM_DATA_W 16

// Extra cycles per phase out of reset
`define SRAM_WAIT_RESET 2

////////////////////////////////////////
// Register block
////////////////////////////////////////

// Byte address width, five registers of four bytes
`define REG_ADDR_W 5

`endif

//--- src/sram_pkg.sv
`default_nettype none

`include "sram_settings.svh"

package sram_pkg;

	// SRAM side
	typedef logic [`SRAM_ADDR_W-1:0] mem_addr_t;
	typedef logic [`SRAM_DATA_W-1:0] mem_data_t;

	// Extra cycles per phase
	typedef logic [3:0] wait_t;

	// Register block
	typedef logic [15:0] count_t;
	typedef logic [31:0] reg_data_t;

	// Owner of an access
	typedef logic [0:0] port_t;
	localparam port_t PORT_FETCH = 1'b0;
	localparam port_t PORT_EXE = 1'b1;

	// Sequencer phases
	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_SETUP,
		SEQ_STROBE,
		SEQ_HOLD
	} seq_state_t;

endpackage

`default_nettype wire

//--- src/sram_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module sram_arbiter
	import sram_pkg::*;
(
	input wire clk,
	input wire rst,

	// Instruction fetch port, read only
	input wire fetch_req,
	input wire mem_addr_t fetch_addr,
	output logic fetch_done,
	output mem_data_t fetch_rdata,

	// Execute port
	input wire exe_req,
	input wire exe_we,
	input wire mem_addr_t exe_addr,
	input wire mem_data_t exe_wdata,
	output logic exe_done,
	output mem_data_t exe_rdata,

	// Towards the sequencer
	output logic acc_start,
	output port_t acc_port,
	output logic acc_we,
	output mem_addr_t acc_addr,
	output mem_data_t acc_wdata,
	input wire acc_busy,
	input wire acc_done,
	input wire port_t done_port,
	input wire mem_data_t acc_rdata
);

	logic fetch_act;
	logic exe_act;
	logic grant_ok;
	logic grant_exe;
	logic grant_fetch;
	logic fetch_hit;
	logic exe_hit;
	logic exe_rd_hit;
	mem_data_t fetch_q;
	mem_data_t exe_q;

	////////////////////////////////////////
	// Grant
	////////////////////////////////////////

	// Sequencer idle and nothing issued last cycle
	assign grant_ok = !acc_busy && !acc_start;

	// Execute wins a tie
	assign grant_exe = grant_ok && exe_req && !exe_act;
	assign grant_fetch = grant_ok && fetch_req && !fetch_act && !grant_exe;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			acc_start <= 1'b0;
			fetch_act <= 1'b0;
			exe_act <= 1'b0;
		end else begin
			acc_start <= grant_exe || grant_fetch;

			// A port stays masked until its own done pulse
			if (grant_exe)
				exe_act <= 1'b1;
			else if (exe_hit)
				exe_act <= 1'b0;

			if (grant_fetch)
				fetch_act <= 1'b1;
			else if (fetch_hit)
				fetch_act <= 1'b0;
		end
	end

	// Access payload, held until the next grant
	always_ff @(posedge clk) begin
		if (grant_exe) begin
			acc_port <= PORT_EXE;
			acc_we <= exe_we;
			acc_addr <= exe_addr;
			acc_wdata <= exe_wdata;
		end else if (grant_fetch) begin
			acc_port <= PORT_FETCH;
			acc_we <= 1'b0;
			acc_addr <= fetch_addr;
		end
	end

	////////////////////////////////////////
	// Completion steering
	////////////////////////////////////////

	assign fetch_hit = acc_done && (done_port == PORT_FETCH);
	assign exe_hit = acc_done && (done_port == PORT_EXE);

	// acc_we still describes the finishing access here
	assign exe_rd_hit = exe_hit && !acc_we;

	assign fetch_done = fetch_hit;
	assign exe_done = exe_hit;

	always_ff @(posedge clk) begin
		if (fetch_hit)
			fetch_q <= acc_rdata;
		if (exe_rd_hit)
			exe_q <= acc_rdata;
	end

	// Bypass so the result is valid during the done pulse itself
	assign fetch_rdata = fetch_hit ? acc_rdata : fetch_q;
	assign exe_rdata = exe_rd_hit ? acc_rdata : exe_q;

endmodule

`default_nettype wire

//--- src/sram_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module sram_sequencer
	import sram_pkg::*;
(
	input wire clk,
	input wire rst,

	// Access request from the arbiter
	input wire acc_start,
	input wire port_t acc_port,
	input wire acc_we,
	input wire mem_addr_t acc_addr,
	input wire mem_data_t acc_wdata,

	// Completion
	output logic acc_busy,
	output logic acc_done,
	output port_t done_port,
	output logic done_we,
	output mem_data_t acc_rdata,

	// Phase length from the register block
	input wire wait_t wait_cycles,

	// SRAM pins, data bus split into both directions
	output mem_addr_t ram_addr,
	output mem_data_t ram_wdata,
	input wire mem_data_t ram_rdata,
	output logic ram_data_oe,
	output logic ram_ce_n,
	output logic ram_oe_n,
	output logic ram_we_n
);

	seq_state_t state;
	wait_t phase_cnt;
	wait_t wait_q;
	logic phase_end;
	logic start_ok;
	port_t port_q;
	logic we_q;
	mem_addr_t addr_q;
	mem_data_t wdata_q;

	assign start_ok = (state == SEQ_IDLE) && acc_start;
	assign phase_end = (phase_cnt == '0);

	////////////////////////////////////////
	// Phase state machine
	////////////////////////////////////////

	// Each phase runs wait_q + 1 cycles
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= SEQ_IDLE;
			phase_cnt <= '0;
			acc_done <= 1'b0;
		end else begin
			acc_done <= 1'b0;
			case (state)
				SEQ_IDLE: begin
					if (acc_start) begin
						state <= SEQ_SETUP;
						phase_cnt <= wait_cycles;
					end
				end
				SEQ_SETUP: begin
					if (phase_end) begin
						state <= SEQ_STROBE;
						phase_cnt <= wait_q;
					end else begin
						phase_cnt <= phase_cnt - 1'b1;
					end
				end
				SEQ_STROBE: begin
					if (phase_end) begin
						state <= SEQ_HOLD;
						phase_cnt <= wait_q;
					end else begin
						phase_cnt <= phase_cnt - 1'b1;
					end
				end
				SEQ_HOLD: begin
					if (phase_end) begin
						state <= SEQ_IDLE;
						acc_done <= 1'b1;
					end else begin
						phase_cnt <= phase_cnt - 1'b1;
					end
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	// Latch the whole access, WAIT changes apply from the next one
	always_ff @(posedge clk) begin
		if (start_ok) begin
			wait_q <= wait_cycles;
			port_q <= acc_port;
			we_q <= acc_we;
			addr_q <= acc_addr;
			wdata_q <= acc_wdata;
		end

		// Read data taken on the last strobe cycle, OE still low
		if ((state == SEQ_STROBE) && phase_end && !we_q)
			acc_rdata <= ram_rdata;
	end

	////////////////////////////////////////
	// Outputs
	////////////////////////////////////////

	assign acc_busy = (state != SEQ_IDLE);
	assign done_port = port_q;
	assign done_we = we_q;

	assign ram_addr = addr_q;
	assign ram_wdata = wdata_q;

	// Chip enabled across setup, strobe and hold
	assign ram_ce_n = (state == SEQ_IDLE);
	assign ram_oe_n = !((state == SEQ_STROBE) && !we_q);
	assign ram_we_n = !((state == SEQ_STROBE) && we_q);

	// Write data stays on the bus through hold, past the WE rising edge
	assign ram_data_oe = we_q && (state != SEQ_IDLE);

endmodule

`default_nettype wire

//--- src/sram_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "sram_settings.svh"

module sram_ctrl_regs
	import sram_pkg::*;
(
	input wire clk,
	input wire rst,

	// AXI4-Lite write channels
	input wire [`REG_ADDR_W-1:0] awaddr,
	input wire awvalid,
	output logic awready,
	input wire reg_data_t wdata,
	input wire wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input wire bready,

	// AXI4-Lite read channels
	input wire [`REG_ADDR_W-1:0] araddr,
	input wire arvalid,
	output logic arready,
	output reg_data_t rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input wire rready,

	// Sequencer status
	input wire acc_busy,
	input wire acc_done,
	input wire port_t done_port,
	input wire done_we,
	output wait_t wait_cycles
);

	localparam int IDX_W = `REG_ADDR_W - 2;
	localparam int N_CNT = 3;

	// Word index of each register
	localparam logic [IDX_W-1:0] IDX_WAIT = 'd0;
	localparam logic [IDX_W-1:0] IDX_STATUS = 'd1;
	localparam logic [IDX_W-1:0] IDX_FETCH_RD = 'd2;
	localparam logic [IDX_W-1:0] IDX_EXE_RD = 'd3;
	localparam logic [IDX_W-1:0] IDX_EXE_WR = 'd4;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	logic aw_got;
	logic w_got;
	logic aw_take;
	logic w_take;
	logic wr_fire;
	logic [`REG_ADDR_W-1:0] aw_addr_q;
	logic [`REG_ADDR_W-1:0] wr_addr;
	reg_data_t w_data_q;
	reg_data_t wr_data;
	logic [IDX_W-1:0] wr_idx;
	logic [IDX_W-1:0] rd_idx;
	reg_data_t rd_word;

	// Counters in order fetch reads, execute reads, execute writes
	count_t cnt [N_CNT];
	logic [N_CNT-1:0] cnt_inc;
	logic [N_CNT-1:0] cnt_clr;

	function automatic logic idx_mapped(input logic [IDX_W-1:0] idx);
		return idx <= IDX_EXE_WR;
	endfunction

	////////////////////////////////////////
	// Write path
	////////////////////////////////////////

	// Address and data accepted independently, both closed by bvalid
	assign awready = !aw_got && !bvalid;
	assign wready = !w_got && !bvalid;
	assign aw_take = awvalid && awready;
	assign w_take = wvalid && wready;

	assign wr_fire = (aw_got || aw_take) && (w_got || w_take);
	assign wr_addr = aw_got ? aw_addr_q : awaddr;
	assign wr_data = w_got ? w_data_q : wdata;
	assign wr_idx = wr_addr[`REG_ADDR_W-1:2];

	always_ff @(posedge clk) begin
		if (aw_take)
			aw_addr_q <= awaddr;
		if (w_take)
			w_data_q <= wdata;
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			aw_got <= 1'b0;
			w_got <= 1'b0;
			bvalid <= 1'b0;
			bresp <= RESP_OKAY;
			wait_cycles <= wait_t'(`SRAM_WAIT_RESET);
		end else begin
			if (bvalid && bready)
				bvalid <= 1'b0;

			if (wr_fire) begin
				aw_got <= 1'b0;
				w_got <= 1'b0;
				bvalid <= 1'b1;
				bresp <= idx_mapped(wr_idx) ? RESP_OKAY : RESP_SLVERR;
				if (wr_idx == IDX_WAIT)
					wait_cycles <= wr_data[$bits(wait_t)-1:0];
			end else begin
				if (aw_take)
					aw_got <= 1'b1;
				if (w_take)
					w_got <= 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// Access counters
	////////////////////////////////////////

	always_comb begin
		cnt_inc[0] = acc_done && (done_port == PORT_FETCH);
		cnt_inc[1] = acc_done && (done_port == PORT_EXE) && !done_we;
		cnt_inc[2] = acc_done && (done_port == PORT_EXE) && done_we;
		for (int i = 0; i < N_CNT; i++)
			cnt_clr[i] = wr_fire && (wr_idx == IDX_FETCH_RD + IDX_W'(i));
	end

	// Saturating, a software clear beats a same cycle increment
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < N_CNT; i++)
				cnt[i] <= '0;
		end else begin
			for (int i = 0; i < N_CNT; i++) begin
				if (cnt_clr[i])
					cnt[i] <= '0;
				else if (cnt_inc[i] && (cnt[i] != '1))
					cnt[i] <= cnt[i] + 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// Read path
	////////////////////////////////////////

	assign arready = !rvalid;
	assign rd_idx = araddr[`REG_ADDR_W-1:2];

	always_comb begin
		case (rd_idx)
			IDX_WAIT: rd_word = reg_data_t'(wait_cycles);
			IDX_STATUS: rd_word = reg_data_t'(acc_busy);
			IDX_FETCH_RD: rd_word = reg_data_t'(cnt[0]);
			IDX_EXE_RD: rd_word = reg_data_t'(cnt[1]);
			IDX_EXE_WR: rd_word = reg_data_t'(cnt[2]);
			default: rd_word = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rvalid <= 1'b0;
			rresp <= RESP_OKAY;
		end else if (rvalid) begin
			if (rready)
				rvalid <= 1'b0;
		end else if (arvalid) begin
			rvalid <= 1'b1;
			rresp <= idx_mapped(rd_idx) ? RESP_OKAY : RESP_SLVERR;
		end
	end

	// Response word, held with rvalid
	always_ff @(posedge clk) begin
		if (arvalid && arready)
			rdata <= rd_word;
	end

endmodule

`default_nettype wire

//--- src/sram_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "sram_settings.svh"

module sram_ctrl_top
	import sram_pkg::*;
(
	input wire clk,
	input wire rst,

	// Fetch port
	input wire fetch_req,
	input wire mem_addr_t fetch_addr,
	output logic fetch_done,
	output mem_data_t fetch_rdata,

	// Execute port
	input wire exe_req,
	input wire exe_we,
	input wire mem_addr_t exe_addr,
	input wire mem_data_t exe_wdata,
	output logic exe_done,
	output mem_data_t exe_rdata,

	// AXI4-Lite slave
	input wire [`REG_ADDR_W-1:0] awaddr,
	input wire awvalid,
	output logic awready,
	input wire reg_data_t wdata,
	input wire wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input wire bready,
	input wire [`REG_ADDR_W-1:0] araddr,
	input wire arvalid,
	output logic arready,
	output reg_data_t rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input wire rready,

	// External SRAM
	output mem_addr_t ram_addr,
	inout wire mem_data_t ram_data,
	output logic ram_ce_n,
	output logic ram_oe_n,
	output logic ram_we_n
);

	logic acc_start;
	port_t acc_port;
	logic acc_we;
	mem_addr_t acc_addr;
	mem_data_t acc_wdata;
	logic acc_busy;
	logic acc_done;
	port_t done_port;
	logic done_we;
	mem_data_t acc_rdata;
	wait_t wait_cycles;
	mem_data_t ram_wdata;
	mem_data_t ram_rdata;
	logic ram_data_oe;

	sram_arbiter arb_i (
		.clk(clk),
		.rst(rst),
		.fetch_req(fetch_req),
		.fetch_addr(fetch_addr),
		.fetch_done(fetch_done),
		.fetch_rdata(fetch_rdata),
		.exe_req(exe_req),
		.exe_we(exe_we),
		.exe_addr(exe_addr),
		.exe_wdata(exe_wdata),
		.exe_done(exe_done),
		.exe_rdata(exe_rdata),
		.acc_start(acc_start),
		.acc_port(acc_port),
		.acc_we(acc_we),
		.acc_addr(acc_addr),
		.acc_wdata(acc_wdata),
		.acc_busy(acc_busy),
		.acc_done(acc_done),
		.done_port(done_port),
		.acc_rdata(acc_rdata)
	);

	sram_sequencer seq_i (
		.clk(clk),
		.rst(rst),
		.acc_start(acc_start),
		.acc_port(acc_port),
		.acc_we(acc_we),
		.acc_addr(acc_addr),
		.acc_wdata(acc_wdata),
		.acc_busy(acc_busy),
		.acc_done(acc_done),
		.done_port(done_port),
		.done_we(done_we),
		.acc_rdata(acc_rdata),
		.wait_cycles(wait_cycles),
		.ram_addr(ram_addr),
		.ram_wdata(ram_wdata),
		.ram_rdata(ram_rdata),
		.ram_data_oe(ram_data_oe),
		.ram_ce_n(ram_ce_n),
		.ram_oe_n(ram_oe_n),
		.ram_we_n(ram_we_n)
	);

	sram_ctrl_regs regs_i (
		.clk(clk),
		.rst(rst),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.acc_busy(acc_busy),
		.acc_done(acc_done),
		.done_port(done_port),
		.done_we(done_we),
		.wait_cycles(wait_cycles)
	);

	// Bidirectional data pins, released unless a write is in flight
	assign ram_data = ram_data_oe ? ram_wdata : 'z;
	assign ram_rdata = ram_data;

endmodule

`default_nettype wire

//--- tb/sram_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "sram_settings.svh"

module sram_model
	import sram_pkg::*;
(
	input wire mem_addr_t ram_addr,
	inout wire mem_data_t ram_data,
	input wire ram_ce_n,
	input wire ram_oe_n,
	input wire ram_we_n
);

	// One word per address, whole chip
	mem_data_t mem [2**`SRAM_ADDR_W];

	////////////////////////////////////////
	// Write on the rising edge of WE
	////////////////////////////////////////

	always @(posedge ram_we_n) begin
		if (ram_ce_n === 1'b0)
			mem[ram_addr] = ram_data;
	end

	////////////////////////////////////////
	// Read, output enabled by CE and OE
	////////////////////////////////////////

	assign ram_data = (!ram_ce_n && !ram_oe_n) ? mem[ram_addr] : 'z;

endmodule

`default_nettype wire

//--- tb/sram_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "sram_settings.svh"

module sram_ctrl_tb
	import sram_pkg::*;
();

	localparam int TIMEOUT = 200;
	localparam int N_WR = 40;
	localparam int N_FETCH = 20;

	localparam logic [`REG_ADDR_W-1:0] REG_WAIT = 5'h00;
	localparam logic [`REG_ADDR_W-1:0] REG_STATUS = 5'h04;
	localparam logic [`REG_ADDR_W-1:0] REG_FETCH_RD = 5'h08;
	localparam logic [`REG_ADDR_W-1:0] REG_EXE_RD = 5'h0c;
	localparam logic [`REG_ADDR_W-1:0] REG_EXE_WR = 5'h10;
	localparam logic [`REG_ADDR_W-1:0] REG_UNMAPPED = 5'h14;
	localparam logic [1:0] OKAY = 2'b00;
	localparam logic [1:0] SLVERR = 2'b10;

	logic clk;
	logic rst;
	logic fetch_req;
	mem_addr_t fetch_addr;
	logic fetch_done;
	mem_data_t fetch_rdata;
	logic exe_req;
	logic exe_we;
	mem_addr_t exe_addr;
	mem_data_t exe_wdata;
	logic exe_done;
	mem_data_t exe_rdata;
	logic [`REG_ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	reg_data_t wdata;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [`REG_ADDR_W-1:0] araddr;
	logic arvalid;
	logic arready;
	reg_data_t rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	mem_addr_t ram_addr;
	wire mem_data_t ram_data;
	logic ram_ce_n;
	logic ram_oe_n;
	logic ram_we_n;

	// Shadow of the SRAM and the accesses still waiting for done
	mem_data_t shadow [mem_addr_t];
	mem_addr_t fetch_exp [$];
	logic [`SRAM_ADDR_W:0] exe_exp [$];
	mem_addr_t addr_list [N_WR];
	wait_t wait_set [3] = '{4'd0, 4'd2, 4'd5};

	int errors = 0;
	int timeouts = 0;
	int n_fetch_rd = 0;
	int n_exe_rd = 0;
	int n_exe_wr = 0;

	sram_ctrl_top dut_i (
		.clk(clk), .rst(rst),
		.fetch_req(fetch_req), .fetch_addr(fetch_addr),
		.fetch_done(fetch_done), .fetch_rdata(fetch_rdata),
		.exe_req(exe_req), .exe_we(exe_we), .exe_addr(exe_addr),
		.exe_wdata(exe_wdata), .exe_done(exe_done), .exe_rdata(exe_rdata),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.ram_addr(ram_addr), .ram_data(ram_data),
		.ram_ce_n(ram_ce_n), .ram_oe_n(ram_oe_n), .ram_we_n(ram_we_n)
	);

	sram_model mem_i (
		.ram_addr(ram_addr), .ram_data(ram_data),
		.ram_ce_n(ram_ce_n), .ram_oe_n(ram_oe_n), .ram_we_n(ram_we_n)
	);

	always #5 clk = ~clk;

	// Expected SRAM word, last value written to the address
	function automatic mem_data_t ref_read(input mem_addr_t addr);
		if (shadow.exists(addr))
			return shadow[addr];
		return 'x;
	endfunction

	// Request seen to done pulse, three phases of WAIT+1 plus the grant cycle
	function automatic int expected_latency(input wait_t w);
		return 3 * (int'(w) + 1) + 1;
	endfunction

	////////////////////////////////////////
	// Done pulse checks
	////////////////////////////////////////

	always @(negedge clk) begin : compare_done
		mem_addr_t f_addr;
		logic [`SRAM_ADDR_W:0] e_ent;
		if (fetch_done === 1'b1) begin
			if (fetch_exp.size() == 0) begin
				errors++;
				$display("fetch_done pulsed at %0t with no fetch request waiting", $time);
			end else begin
				f_addr = fetch_exp.pop_front();
				assert (fetch_rdata === ref_read(f_addr)) else begin
					errors++;
					$display("** Error at %0t: fetch of %h returned %h, expected %h",
						$time, f_addr, fetch_rdata, ref_read(f_addr));
				end
			end
		end
		if (exe_done === 1'b1) begin
			if (exe_exp.size() == 0) begin
				errors++;
				$display("exe_done pulsed at %0t with no execute request waiting", $time);
			end else begin
				e_ent = exe_exp.pop_front();
				// Writes only complete, no data to compare
				if (!e_ent[`SRAM_ADDR_W]) begin
					assert (exe_rdata === ref_read(e_ent[`SRAM_ADDR_W-1:0])) else begin
						errors++;
						$display("** Error at %0t: execute read of %h returned %h, expected %h",
							$time, e_ent[`SRAM_ADDR_W-1:0], exe_rdata,
							ref_read(e_ent[`SRAM_ADDR_W-1:0]));
					end
				end
			end
		end
	end

	////////////////////////////////////////
	// Port drivers
	////////////////////////////////////////

	// Entered 1 ns after a rising edge, left the same way
	task automatic exe_access(input logic we, input mem_addr_t addr, input mem_data_t data,
			output int cycles);
		logic got;
		got = 1'b0;
		cycles = 0;
		exe_we = we;
		exe_addr = addr;
		exe_wdata = data;
		exe_req = 1'b1;
		if (we) begin
			shadow[addr] = data;
			n_exe_wr++;
		end else begin
			n_exe_rd++;
		end
		exe_exp.push_back({we, addr});
		while (!got && cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
			@(negedge clk);
			got = exe_done;
		end
		if (!got) begin
			timeouts++;
			$display("Execute access to %h got no exe_done within %0d cycles", addr, TIMEOUT);
		end
		@(posedge clk);
		#1;
		exe_req = 1'b0;
	endtask

	task automatic fetch_read(input mem_addr_t addr, output int cycles);
		logic got;
		got = 1'b0;
		cycles = 0;
		fetch_addr = addr;
		fetch_req = 1'b1;
		n_fetch_rd++;
		fetch_exp.push_back(addr);
		while (!got && cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
			@(negedge clk);
			got = fetch_done;
		end
		if (!got) begin
			timeouts++;
			$display("Fetch of %h got no fetch_done within %0d cycles", addr, TIMEOUT);
		end
		@(posedge clk);
		#1;
		fetch_req = 1'b0;
	endtask

	////////////////////////////////////////
	// AXI4-Lite master
	////////////////////////////////////////

	task automatic reg_write(input logic [`REG_ADDR_W-1:0] addr, input reg_data_t data,
			output logic [1:0] resp);
		logic aw_fire;
		logic w_fire;
		logic got;
		int cycles;
		got = 1'b0;
		cycles = 0;
		resp = 2'bxx;
		awaddr = addr;
		awvalid = 1'b1;
		wdata = data;
		wvalid = 1'b1;
		bready = 1'b1;
		while ((awvalid || wvalid) && cycles < TIMEOUT) begin
			@(negedge clk);
			aw_fire = awvalid && awready;
			w_fire = wvalid && wready;
			@(posedge clk);
			#1;
			cycles++;
			if (aw_fire)
				awvalid = 1'b0;
			if (w_fire)
				wvalid = 1'b0;
		end
		awvalid = 1'b0;
		wvalid = 1'b0;
		cycles = 0;
		while (!got && cycles < TIMEOUT) begin
			@(negedge clk);
			got = bvalid;
			resp = bresp;
			@(posedge clk);
			#1;
			cycles++;
		end
		bready = 1'b0;
		if (!got) begin
			timeouts++;
			$display("Register write to %h got no write response in time", addr);
		end
	endtask

	task automatic reg_read(input logic [`REG_ADDR_W-1:0] addr, output reg_data_t data,
			output logic [1:0] resp);
		logic ar_fire;
		logic got;
		int cycles;
		got = 1'b0;
		cycles = 0;
		data = 'x;
		resp = 2'bxx;
		araddr = addr;
		arvalid = 1'b1;
		rready = 1'b1;
		while (arvalid && cycles < TIMEOUT) begin
			@(negedge clk);
			ar_fire = arvalid && arready;
			@(posedge clk);
			#1;
			cycles++;
			if (ar_fire)
				arvalid = 1'b0;
		end
		arvalid = 1'b0;
		cycles = 0;
		while (!got && cycles < TIMEOUT) begin
			@(negedge clk);
			got = rvalid;
			data = rdata;
			resp = rresp;
			@(posedge clk);
			#1;
			cycles++;
		end
		rready = 1'b0;
		if (!got) begin
			timeouts++;
			$display("Register read of %h got no read response in time", addr);
		end
	endtask

	task automatic expect_reg(input logic [`REG_ADDR_W-1:0] addr, input reg_data_t exp_data,
			input logic [1:0] exp_resp);
		reg_data_t data;
		logic [1:0] resp;
		reg_read(addr, data, resp);
		assert (data === exp_data && resp === exp_resp) else begin
			errors++;
			$display("** Error at %0t: register %h read %h resp %b, expected %h resp %b",
				$time, addr, data, resp, exp_data, exp_resp);
		end
	endtask

	task automatic expect_resp(input logic [1:0] resp, input logic [1:0] exp_resp,
			input logic [`REG_ADDR_W-1:0] addr);
		assert (resp === exp_resp) else begin
			errors++;
			$display("** Error at %0t: write to register %h answered %b, expected %b",
				$time, addr, resp, exp_resp);
		end
	endtask

	task automatic check_idle_pins();
		assert (ram_ce_n === 1'b1 && ram_oe_n === 1'b1 && ram_we_n === 1'b1
				&& bvalid === 1'b0 && rvalid === 1'b0) else begin
			errors++;
			$display("** Error at %0t: strobes or AXI valids not idle around reset", $time);
		end
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		int unsigned seed;
		int cyc;
		int cyc_exe;
		int cyc_fetch;
		logic [1:0] resp;
		logic [`REG_ADDR_W-1:0] cnt_addr [3];
		seed = $urandom(73);
		cnt_addr = '{REG_FETCH_RD, REG_EXE_RD, REG_EXE_WR};
		clk = 1'b0;
		rst = 1'b0;
		fetch_req = 1'b0;
		fetch_addr = '0;
		exe_req = 1'b0;
		exe_we = 1'b0;
		exe_addr = '0;
		exe_wdata = '0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;

		// Reset values
		repeat (5) @(posedge clk);
		#1;
		check_idle_pins();
		rst = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		check_idle_pins();
		expect_reg(REG_WAIT, `SRAM_WAIT_RESET, OKAY);
		for (int i = 0; i < 3; i++)
			expect_reg(cnt_addr[i], 0, OKAY);

		// Random writes, then read back over the execute port
		for (int i = 0; i < N_WR; i++) begin
			addr_list[i] = mem_addr_t'($urandom);
			exe_access(1'b1, addr_list[i], mem_data_t'($urandom), cyc);
		end
		for (int i = 0; i < N_WR; i++)
			exe_access(1'b0, addr_list[i], '0, cyc);

		// Fetch reads, then both ports in the same cycle
		for (int i = 0; i < N_FETCH; i++)
			fetch_read(addr_list[i], cyc);
		fork
			exe_access(1'b0, addr_list[5], '0, cyc_exe);
			fetch_read(addr_list[6], cyc_fetch);
		join
		assert (cyc_exe < cyc_fetch) else begin
			errors++;
			$display("** Error at %0t: exe_done after %0d cycles, fetch_done after %0d",
				$time, cyc_exe, cyc_fetch);
		end

		// Latency for several phase lengths
		for (int i = 0; i < 3; i++) begin
			reg_write(REG_WAIT, reg_data_t'(wait_set[i]), resp);
			expect_resp(resp, OKAY, REG_WAIT);
			expect_reg(REG_WAIT, reg_data_t'(wait_set[i]), OKAY);
			exe_access(1'b0, addr_list[i], '0, cyc);
			// First counted edge is the one that samples the request
			assert (cyc - 1 == expected_latency(wait_set[i])) else begin
				errors++;
				$display("** Error at %0t: WAIT %0d gave latency %0d, expected %0d",
					$time, wait_set[i], cyc - 1, expected_latency(wait_set[i]));
			end
			fetch_read(addr_list[i + 3], cyc);
			assert (cyc - 1 == expected_latency(wait_set[i])) else begin
				errors++;
				$display("** Error at %0t: WAIT %0d gave fetch latency %0d, expected %0d",
					$time, wait_set[i], cyc - 1, expected_latency(wait_set[i]));
			end
		end

		// Busy flag seen in the middle of a long access
		fork
			exe_access(1'b0, addr_list[7], '0, cyc);
			begin
				repeat (4) @(posedge clk);
				#1;
				expect_reg(REG_STATUS, 1, OKAY);
			end
		join

		// Counters, status and decode errors
		expect_reg(REG_FETCH_RD, n_fetch_rd, OKAY);
		expect_reg(REG_EXE_RD, n_exe_rd, OKAY);
		expect_reg(REG_EXE_WR, n_exe_wr, OKAY);
		expect_reg(REG_STATUS, 0, OKAY);
		reg_write(REG_STATUS, 32'h1, resp);
		expect_resp(resp, OKAY, REG_STATUS);
		for (int i = 0; i < 3; i++) begin
			reg_write(cnt_addr[i], 32'hffff_ffff, resp);
			expect_resp(resp, OKAY, cnt_addr[i]);
			expect_reg(cnt_addr[i], 0, OKAY);
		end
		reg_write(REG_UNMAPPED, 32'h1234, resp);
		expect_resp(resp, SLVERR, REG_UNMAPPED);
		expect_reg(REG_UNMAPPED, 0, SLVERR);

		repeat (3) @(posedge clk);
		$display("Errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+src
src/sram_pkg.sv
src/sram_arbiter.sv
src/sram_sequencer.sv
src/sram_ctrl_regs.sv
src/sram_ctrl_top.sv
tb/sram_model.sv
tb/sram_ctrl_tb.sv

//--- Makefile
# Verilator build and run of the SRAM controller testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module sram_ctrl_tb \
		-f flist.f -Mdir obj_dir
	@out="$$(./obj_dir/Vsram_ctrl_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf obj_dir
